// ==== src/regfetch_macros.svh ====
`ifndef REGFETCH_MACROS_SVH
`define REGFETCH_MACROS_SVH

// integer datapath width
`define REGFETCH_DATA_WIDTH 32

// register index width, enough to address every architectural register
`define REGFETCH_ADDR_WIDTH 5

// architectural register count, register 0 included
`define REGFETCH_REG_COUNT 32

`endif

// ==== src/regfetch_pkg.sv ====
`default_nettype none

`include "regfetch_macros.svh"

package regfetch_pkg;

    typedef logic [`REGFETCH_DATA_WIDTH-1:0] data_t;
    typedef logic [`REGFETCH_ADDR_WIDTH-1:0] reg_addr_t;

    // decode request, presented for one issue slot
    typedef struct packed {
        logic      read_en_1;
        logic      read_en_2;
        reg_addr_t read_addr_1;
        reg_addr_t read_addr_2;
        logic      write_en;
        reg_addr_t write_addr;
        logic      is_load;
    } issue_t;

    // one in-flight destination as seen by the forwarding logic
    typedef struct packed {
        logic      write_en;
        reg_addr_t write_addr;
        logic      is_load;
        data_t     data;
    } stage_dest_t;

    // register file write port
    typedef struct packed {
        logic      write_en;
        reg_addr_t write_addr;
        data_t     data;
    } wb_write_t;

endpackage

`default_nettype wire

// ==== src/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "regfetch_macros.svh"

module reg_file (
    input  wire                     clk,
    input  wire regfetch_pkg::reg_addr_t read_addr_1,
    input  wire regfetch_pkg::reg_addr_t read_addr_2,
    input  wire regfetch_pkg::wb_write_t wb_write,
    output regfetch_pkg::data_t     reg_data_1,
    output regfetch_pkg::data_t     reg_data_2
);

    // register 0 has no storage
    regfetch_pkg::data_t regs [1:`REGFETCH_REG_COUNT-1];

    // zero register first, then the pending write, then storage
    function automatic regfetch_pkg::data_t read_port(
        input regfetch_pkg::reg_addr_t addr,
        input regfetch_pkg::wb_write_t wb,
        input regfetch_pkg::data_t     stored
    );
        if (addr == '0) begin
            return '0;
        end
        if (wb.write_en && (wb.write_addr == addr)) begin
            return wb.data;
        end
        return stored;
    endfunction

    // writes to register 0 are dropped
    always_ff @(posedge clk) begin
        if (wb_write.write_en && (wb_write.write_addr != '0)) begin
            regs[wb_write.write_addr] <= wb_write.data;
        end
    end

    // write-through, so WB and a same-cycle read agree
    assign reg_data_1 = read_port(read_addr_1, wb_write, regs[read_addr_1]);
    assign reg_data_2 = read_port(read_addr_2, wb_write, regs[read_addr_2]);

endmodule

`default_nettype wire

// ==== src/reg_read_proxy.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_read_proxy (
    input  wire regfetch_pkg::issue_t      issue,
    input  wire regfetch_pkg::data_t       reg_data_1,
    input  wire regfetch_pkg::data_t       reg_data_2,
    input  wire regfetch_pkg::stage_dest_t ex_dest,
    input  wire regfetch_pkg::stage_dest_t mem_dest,
    output logic                           load_related_1,
    output logic                           load_related_2,
    output regfetch_pkg::data_t            operand_1,
    output regfetch_pkg::data_t            operand_2
);

    // EX is younger than MEM, so it has the newer value
    function automatic regfetch_pkg::data_t forward(
        input logic                     read_en,
        input regfetch_pkg::reg_addr_t  read_addr,
        input regfetch_pkg::data_t      reg_data,
        input regfetch_pkg::stage_dest_t ex,
        input regfetch_pkg::stage_dest_t mem
    );
        if (!read_en) begin
            return '0;
        end
        if (ex.write_en && (read_addr == ex.write_addr)) begin
            return ex.data;
        end
        if (mem.write_en && (read_addr == mem.write_addr)) begin
            return mem.data;
        end
        return reg_data;
    endfunction

    // load data only arrives at the end of MEM
    function automatic logic load_hit(
        input logic                      read_en,
        input regfetch_pkg::reg_addr_t   read_addr,
        input regfetch_pkg::stage_dest_t ex,
        input regfetch_pkg::stage_dest_t mem
    );
        logic ex_hit;
        logic mem_hit;
        ex_hit  = ex.is_load && (read_addr == ex.write_addr);
        mem_hit = mem.is_load && (read_addr == mem.write_addr);
        return read_en && (ex_hit || mem_hit);
    endfunction

    assign load_related_1 = load_hit(issue.read_en_1, issue.read_addr_1, ex_dest, mem_dest);
    assign load_related_2 = load_hit(issue.read_en_2, issue.read_addr_2, ex_dest, mem_dest);

    assign operand_1 = forward(issue.read_en_1, issue.read_addr_1, reg_data_1,
                               ex_dest, mem_dest);
    assign operand_2 = forward(issue.read_en_2, issue.read_addr_2, reg_data_2,
                               ex_dest, mem_dest);

endmodule

`default_nettype wire

// ==== src/dest_pipeline.sv ====
`timescale 1ns/100ps
`default_nettype none

module dest_pipeline (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire logic                      issue_valid,
    input  wire regfetch_pkg::issue_t      issue,
    input  wire logic                      load_related_1,
    input  wire logic                      load_related_2,
    input  wire regfetch_pkg::data_t       ex_data,
    input  wire regfetch_pkg::data_t       mem_data,
    output regfetch_pkg::stage_dest_t      ex_dest,
    output regfetch_pkg::stage_dest_t      mem_dest,
    output regfetch_pkg::wb_write_t        wb_write,
    output logic                           stall,
    output logic                           operand_valid
);

    // EX stage, the result comes from outside while it sits here
    logic                    ex_write_en;
    logic                    ex_is_load;
    regfetch_pkg::reg_addr_t ex_write_addr;

    regfetch_pkg::stage_dest_t mem_q;
    regfetch_pkg::wb_write_t   wb_q;

    // hold decode on any load hazard
    assign stall         = issue_valid && (load_related_1 || load_related_2);
    assign operand_valid = issue_valid && !stall;

    // issue into EX, a bubble when nothing is accepted
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_write_en <= 1'b0;
            ex_is_load  <= 1'b0;
        end else begin
            // register 0 is never a live destination
            ex_write_en <= operand_valid && issue.write_en && (issue.write_addr != '0);
            ex_is_load  <= operand_valid && issue.is_load;
        end
    end

    always_ff @(posedge clk) begin
        ex_write_addr <= issue.write_addr;
    end

    // EX to MEM, ALU result captured here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_q.write_en <= 1'b0;
            mem_q.is_load  <= 1'b0;
        end else begin
            mem_q.write_en <= ex_write_en;
            mem_q.is_load  <= ex_is_load;
        end
    end

    always_ff @(posedge clk) begin
        mem_q.write_addr <= ex_write_addr;
        mem_q.data       <= ex_data;
    end

    // MEM to WB, loads pick up memory data, others keep the EX result
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q.write_en <= 1'b0;
        end else begin
            wb_q.write_en <= mem_q.write_en;
        end
    end

    always_ff @(posedge clk) begin
        wb_q.write_addr <= mem_q.write_addr;
        wb_q.data       <= mem_q.is_load ? mem_data : mem_q.data;
    end

    assign ex_dest = '{
        write_en:   ex_write_en,
        write_addr: ex_write_addr,
        is_load:    ex_is_load,
        data:       ex_data
    };

    assign mem_dest = mem_q;
    assign wb_write = wb_q;

    // decode keeps the stalled request on the next cycle
    a_stall_needs_issue: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> (issue_valid && $stable(issue))
    ) else $error("dest_pipeline: stall without a held issue");

    // a live load leaving MEM lands in WB with a real destination
    a_load_wb_dest: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_q.is_load && mem_q.write_en) |=> (wb_q.write_en && (wb_q.write_addr != '0))
    ) else $error("dest_pipeline: load reached WB writing register 0");

endmodule

`default_nettype wire

// ==== src/operand_fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_fetch_top (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire logic                 issue_valid,
    input  wire regfetch_pkg::issue_t issue,
    input  wire regfetch_pkg::data_t  ex_data,
    input  wire regfetch_pkg::data_t  mem_data,
    output regfetch_pkg::data_t       operand_1,
    output regfetch_pkg::data_t       operand_2,
    output logic                      operand_valid,
    output logic                      stall
);

    regfetch_pkg::data_t       reg_data_1;
    regfetch_pkg::data_t       reg_data_2;
    regfetch_pkg::stage_dest_t ex_dest;
    regfetch_pkg::stage_dest_t mem_dest;
    regfetch_pkg::wb_write_t   wb_write;
    logic                      load_related_1;
    logic                      load_related_2;

    // register file, written back from WB
    reg_file u_reg_file (
        .clk         (clk),
        .read_addr_1 (issue.read_addr_1),
        .read_addr_2 (issue.read_addr_2),
        .wb_write    (wb_write),
        .reg_data_1  (reg_data_1),
        .reg_data_2  (reg_data_2)
    );

    // forwarding and load hazard detection
    reg_read_proxy u_reg_read_proxy (
        .issue          (issue),
        .reg_data_1     (reg_data_1),
        .reg_data_2     (reg_data_2),
        .ex_dest        (ex_dest),
        .mem_dest       (mem_dest),
        .load_related_1 (load_related_1),
        .load_related_2 (load_related_2),
        .operand_1      (operand_1),
        .operand_2      (operand_2)
    );

    // in-flight destinations, stall and write-back
    dest_pipeline u_dest_pipeline (
        .clk            (clk),
        .rst_n          (rst_n),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .load_related_1 (load_related_1),
        .load_related_2 (load_related_2),
        .ex_data        (ex_data),
        .mem_data       (mem_data),
        .ex_dest        (ex_dest),
        .mem_dest       (mem_dest),
        .wb_write       (wb_write),
        .stall          (stall),
        .operand_valid  (operand_valid)
    );

endmodule

`default_nettype wire

// ==== verification/operand_fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_fetch_tb;

    localparam int MAX_LINES   = 64;
    localparam     GOLDEN_PATH = "verification/operand_fetch_golden.txt";

    logic                 clk;
    logic                 rst_n;
    logic                 issue_valid;
    regfetch_pkg::issue_t issue;
    regfetch_pkg::data_t  ex_data;
    regfetch_pkg::data_t  mem_data;
    regfetch_pkg::data_t  operand_1;
    regfetch_pkg::data_t  operand_2;
    logic                 operand_valid;
    logic                 stall;

    // one entry per golden line, stimulus then expected outputs
    int                   line_test     [MAX_LINES];
    logic                 line_valid    [MAX_LINES];
    regfetch_pkg::issue_t line_issue    [MAX_LINES];
    regfetch_pkg::data_t  line_ex_data  [MAX_LINES];
    regfetch_pkg::data_t  line_mem_data [MAX_LINES];
    logic                 exp_stall     [MAX_LINES];
    logic                 exp_valid     [MAX_LINES];
    regfetch_pkg::data_t  exp_operand_1 [MAX_LINES];
    regfetch_pkg::data_t  exp_operand_2 [MAX_LINES];

    int num_lines;
    int cycle_limit;
    int cycle_count;
    int tests_passed;
    int tests_failed;
    bit golden_loaded;

    operand_fetch_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue         (issue),
        .ex_data       (ex_data),
        .mem_data      (mem_data),
        .operand_1     (operand_1),
        .operand_2     (operand_2),
        .operand_valid (operand_valid),
        .stall         (stall)
    );

    always #10 clk = ~clk;

    // lines without the full column set are comments or blank
    task automatic load_golden(output int count);
        int                   fd;
        int                   n;
        int                   test_num;
        string                text;
        logic [31:0]          field [14];
        regfetch_pkg::issue_t req;
        count = 0;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(text, fd) != 0 && count < MAX_LINES) begin
            n = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h", test_num,
                        field[0], field[1], field[2], field[3], field[4], field[5], field[6],
                        field[7], field[8], field[9], field[10], field[11], field[12],
                        field[13]);
            if (n == 15) begin
                req.read_en_1   = field[1][0];
                req.read_en_2   = field[2][0];
                req.read_addr_1 = field[3][4:0];
                req.read_addr_2 = field[4][4:0];
                req.write_en    = field[5][0];
                req.write_addr  = field[6][4:0];
                req.is_load     = field[7][0];
                line_test[count]     = test_num;
                line_valid[count]    = field[0][0];
                line_issue[count]    = req;
                line_ex_data[count]  = field[8];
                line_mem_data[count] = field[9];
                exp_stall[count]     = field[10][0];
                exp_valid[count]     = field[11][0];
                exp_operand_1[count] = field[12];
                exp_operand_2[count] = field[13];
                count++;
            end
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        issue_valid = 1'b0;
        issue       = '0;
        ex_data     = '0;
        mem_data    = '0;
    endtask

    task automatic apply_line(input int idx);
        issue_valid = line_valid[idx];
        issue       = line_issue[idx];
        ex_data     = line_ex_data[idx];
        mem_data    = line_mem_data[idx];
    endtask

    task automatic check_line(input int idx, inout int errors);
        assert (stall === exp_stall[idx]) else begin
            $display("MISMATCH time %0t signal stall expected %0b actual %0b",
                     $time, exp_stall[idx], stall);
            errors++;
        end
        assert (operand_valid === exp_valid[idx]) else begin
            $display("MISMATCH time %0t signal operand_valid expected %0b actual %0b",
                     $time, exp_valid[idx], operand_valid);
            errors++;
        end
        assert (operand_1 === exp_operand_1[idx]) else begin
            $display("MISMATCH time %0t signal operand_1 expected %h actual %h",
                     $time, exp_operand_1[idx], operand_1);
            errors++;
        end
        assert (operand_2 === exp_operand_2[idx]) else begin
            $display("MISMATCH time %0t signal operand_2 expected %h actual %h",
                     $time, exp_operand_2[idx], operand_2);
            errors++;
        end
    endtask

    task automatic report_test(input int test_num, input int lines, input int errors);
        if (errors == 0) begin
            tests_passed++;
            $display("test %0d passed, %0d cycles", test_num, lines);
        end else begin
            tests_failed++;
            $display("test %0d failed, %0d cycles, %0d mismatches", test_num, lines, errors);
        end
    endtask

    // entered 2 ns after a rising edge, checks land just before the next one
    task automatic run_lines();
        int idx;
        int current_test;
        int test_lines;
        int test_errors;
        current_test = line_test[0];
        test_lines   = 0;
        test_errors  = 0;
        for (idx = 0; idx < num_lines; idx++) begin
            if (line_test[idx] != current_test) begin
                report_test(current_test, test_lines, test_errors);
                current_test = line_test[idx];
                test_lines   = 0;
                test_errors  = 0;
            end
            apply_line(idx);
            #16;
            check_line(idx, test_errors);
            test_lines++;
            @(posedge clk);
            #2;
        end
        report_test(current_test, test_lines, test_errors);
        drive_idle();
    endtask

    initial begin : watchdog
        cycle_count = 0;
        wait (golden_loaded);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the golden sequence did not complete", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        tests_passed = 0;
        tests_failed = 0;
        drive_idle();
        load_golden(num_lines);
        if (num_lines == 0) begin
            $display("golden file %s could not be opened or holds no lines", GOLDEN_PATH);
            $display("TB FAILED");
            $finish;
        end else begin
            cycle_limit   = num_lines + 20;
            golden_loaded = 1'b1;
            repeat (2) @(posedge clk);
            #2;
            rst_n = 1'b1;
            run_lines();
            $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
            if (tests_failed == 0 && tests_passed > 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/operand_fetch_golden.txt ====
// test valid re1 re2 ra1 ra2 we wa load ex_data mem_data stall op_valid operand_1 operand_2
// one line per clock cycle, test number in decimal, all other columns in hex
// test 1 idle after reset, disabled reads and register 0
1 0 0 0 00 00 0 00 0 00000000 00000000 0 0 00000000 00000000
1 1 0 0 05 06 0 00 0 00000000 00000000 0 1 00000000 00000000
1 1 1 1 00 00 0 00 0 00000000 00000000 0 1 00000000 00000000
// test 2 write r1, write-through read at distance 3, file read, write to r0 dropped
2 1 0 0 00 00 1 01 0 00000000 00000000 0 1 00000000 00000000
2 0 0 0 00 00 0 00 0 11111111 00000000 0 0 00000000 00000000
2 1 0 0 00 00 1 00 0 00000000 00000000 0 1 00000000 00000000
2 1 1 1 01 00 0 00 0 99999999 00000000 0 1 11111111 00000000
2 1 1 1 01 01 0 00 0 00000000 00000000 0 1 11111111 11111111
2 1 1 1 00 01 0 00 0 00000000 00000000 0 1 00000000 11111111
// test 3 EX and MEM forwarding, EX wins when both match
3 1 0 0 00 00 1 02 0 00000000 00000000 0 1 00000000 00000000
3 1 1 0 02 00 1 03 0 22222222 00000000 0 1 22222222 00000000
3 1 1 1 02 03 1 03 0 33333333 00000000 0 1 22222222 33333333
3 1 1 1 03 02 0 00 0 44444444 00000000 0 1 44444444 22222222
3 1 1 1 03 01 0 00 0 00000000 00000000 0 1 44444444 11111111
3 0 0 0 00 00 0 00 0 00000000 00000000 0 0 00000000 00000000
// test 4 load-use at distance 1 stalls two cycles, at distance 2 one cycle
4 1 0 0 00 00 1 04 1 00000000 00000000 0 1 00000000 00000000
4 1 1 0 04 00 1 05 0 00000000 00000000 1 0 00000000 00000000
4 1 1 0 04 00 1 05 0 00000000 55555555 1 0 00000000 00000000
4 1 1 0 04 00 1 05 0 00000000 00000000 0 1 55555555 00000000
4 1 0 0 00 00 1 06 1 12345678 00000000 0 1 00000000 00000000
4 1 1 0 05 00 0 00 0 00000000 00000000 0 1 12345678 00000000
4 1 1 1 06 05 1 07 0 00000000 77777777 1 0 00000000 12345678
4 1 1 1 06 05 1 07 0 00000000 00000000 0 1 77777777 12345678
// test 5 independent reads while a load is in EX and MEM
5 1 0 0 00 00 1 08 1 0a0a0a0a 00000000 0 1 00000000 00000000
5 1 1 1 01 07 0 00 0 00000000 00000000 0 1 11111111 0a0a0a0a
5 1 1 0 03 08 0 00 0 00000000 88888888 0 1 44444444 00000000
5 1 1 1 08 06 0 00 0 00000000 00000000 0 1 88888888 77777777
5 0 0 0 00 00 0 00 0 00000000 00000000 0 0 00000000 00000000

// ==== tb.f ====
+incdir+src
src/regfetch_pkg.sv
src/reg_file.sv
src/reg_read_proxy.sv
src/dest_pipeline.sv
src/operand_fetch_top.sv
verification/operand_fetch_tb.sv
